//--- soc_testdata.txt
# cmd address  sel wdata    expected   (all hex)
# cmd 0 write 1 read 2 pins 3 irq_wait 4 irq 5 button 6 busy_write 7 frame 8 idle 9 save a greater
4 00000000 0 00000000 00000000
0 00000000 f 11223344 00000000
0 00000004 f aabbccdd 00000000
0 00000000 5 55667788 00000000
0 00000004 a 00ee0000 00000000
0 000003fc f deadbeef 00000000
0 000003fc 3 0000cafe 00000000
1 00000000 f 00000000 11663388
1 00000004 f 00000000 00bb00dd
1 000003fc f 00000000 deadcafe
1 00000400 f 00000000 11663388
0 80000000 f 123456a5 00000000
0 80000004 f ffffff3c 00000000
2 00000000 0 00000000 00003ca5
1 80000000 f 00000000 000000a5
1 80000004 f 00000000 0000003c
1 80000014 f 00000000 00000000
1 8000000c f 00000000 00000000
9 20000000 f 00000000 00000000
a 20000000 f 00000000 00000000
0 20000008 f 00000200 00000000
0 2000000c f 00000000 00000000
3 00000007 0 00000000 00000001
0 2000000c f ffffffff 00000000
0 20000008 f ffffffff 00000000
3 00000007 0 00000000 00000000
5 00000000 0 00000001 00000000
3 0000000b 0 00000000 00000001
1 80000008 f 00000000 00000003
0 80000008 1 00000002 00000000
4 00000000 0 00000000 00000000
8 00000000 0 00000014 00000000
1 80000008 f 00000000 00000001
5 00000000 0 00000000 00000000
0 8000000c 1 0000005a 00000000
1 80000010 f 00000000 00000001
6 8000000c 1 000000c3 0000005a
7 00000000 0 00000000 000000c3
8 00000000 0 00000020 00000000
1 80000010 f 00000000 00000000

//--- flist.f
+incdir+.
soc_pkg.sv
wb_if.sv
bus_decoder.sv
data_ram.sv
rtc_timer.sv
periph_ctrl.sv
soc_platform.sv
soc_props.sv
tb_soc_platform.sv

//--- Makefile
TOP := tb_soc_platform

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f flist.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f flist.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "NO ERRORS"

clean:
	rm -rf obj_dir

//--- tb_soc_platform.sv
`include "soc_consts.svh"

module tb_soc_platform;
    import soc_pkg::*;

    localparam int ack_timeout  = 1000;     // uart back-pressure lasts about 170 cycles
    localparam int irq_timeout  = 4000;
    localparam int edge_timeout = 400;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_we;
    addr_t      wb_adr;
    sel_t       wb_sel;
    data_t      wb_dat;
    data_t      wb_dat_o;
    logic       wb_ack;
    logic       btn;
    logic [7:0] gpio_out;
    logic [7:0] gpio_addr;
    logic       uart_tx;
    irq_vec_t   irq;
    int         cycle_cnt = 0;
    logic       tx_seen = 1'b1;
    int         fall_cycle = 0;

    soc_platform soc_platform_i (
        .clk         (clk),
        .rst_n_i     (rst_n),
        .wb_cyc_i    (wb_cyc),
        .wb_stb_i    (wb_stb),
        .wb_we_i     (wb_we),
        .wb_adr_i    (wb_adr),
        .wb_sel_i    (wb_sel),
        .wb_dat_i    (wb_dat),
        .wb_dat_o    (wb_dat_o),
        .wb_ack_o    (wb_ack),
        .btn_i       (btn),
        .gpio_out_o  (gpio_out),
        .gpio_addr_o (gpio_addr),
        .uart_tx_o   (uart_tx),
        .irq_o       (irq)
    );

    bind soc_platform soc_props soc_props_i (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .wb_stb_i     (wb_stb_i),
        .wb_ack_o     (wb_ack_o),
        .uart_tx_o    (uart_tx_o),
        .irq_o        (irq_o),
        .uart_state_i (periph_ctrl_i.uart_state)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;     // time stamps for ordering checks
    end

    // cycle stamp of the latest falling edge on the uart line
    always @(negedge clk) begin
        tx_seen <= uart_tx;
        if (tx_seen && !uart_tx) begin
            fall_cycle <= cycle_cnt;
        end
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            fail_run($sformatf("MISMATCH %s expected %08h actual %08h", name, expected, actual));
        end
    endtask

    function automatic string step_label(input logic [31:0] cmd);
        case (cmd)
            32'h0:   return "write";
            32'h1:   return "read";
            32'h2:   return "pins";
            32'h3:   return "irq_wait";
            32'h4:   return "irq";
            32'h5:   return "button";
            32'h6:   return "busy_write";
            32'h7:   return "frame";
            32'h8:   return "idle";
            32'h9:   return "save";
            32'ha:   return "greater";
            default: return "unknown";
        endcase
    endfunction

    //////////////////////////////////////////////////////////////////////
    // bus master, interrupt and uart line helpers
    //////////////////////////////////////////////////////////////////////

    task automatic bus_cycle(input logic we, input addr_t adr, input sel_t sel, input data_t dat,
                             output data_t rdat, output int ack_cycle);
        int n;
        n = 0;
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we  <= we;
        wb_adr <= adr;
        wb_sel <= sel;
        wb_dat <= dat;
        @(negedge clk);
        while (!wb_ack) begin
            n++;
            if (n > ack_timeout) begin
                fail_run($sformatf("bus cycle to %08h was never acknowledged", adr));
            end
            @(negedge clk);
        end
        rdat      = wb_dat_o;
        ack_cycle = cycle_cnt;
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic wait_irq(input int bit_pos, input logic level);
        int n;
        n = 0;
        @(negedge clk);
        while (irq[bit_pos] !== level) begin
            n++;
            if (n > irq_timeout) begin
                fail_run($sformatf("interrupt bit %0d never reached %0b", bit_pos, level));
            end
            @(negedge clk);
        end
    endtask

    // bit centres are timed from the falling edge that opened the start bit
    task automatic capture_frame(input string name, input logic [7:0] exp_byte,
                                 output int end_cycle);
        int         n;
        int         lag;
        logic [7:0] got;
        n = 0;
        @(negedge clk);
        while (uart_tx !== 1'b0) begin
            n++;
            if (n > edge_timeout) begin
                fail_run("uart start bit did not appear");
            end
            @(negedge clk);
        end
        @(negedge clk);
        lag = cycle_cnt - fall_cycle;   // the start bit may already be under way
        repeat (`UART_DIV / 2 - lag) @(negedge clk);
        check_value({name, "_start"}, 32'h0, {31'h0, uart_tx});
        for (int b = 0; b < 8; b++) begin
            repeat (`UART_DIV) @(negedge clk);
            got[b] = uart_tx;
        end
        repeat (`UART_DIV) @(negedge clk);
        check_value({name, "_stop"}, 32'h1, {31'h0, uart_tx});
        check_value(name, {24'h0, exp_byte}, {24'h0, got});
        end_cycle = cycle_cnt;
    endtask

    initial begin
        int          fd;
        int          lineno;
        int          n_cmds;
        int          ack_cycle;
        int          frame_end;
        string       line;
        string       name;
        logic [31:0] cmd;
        logic [31:0] adr;
        logic [31:0] sel;
        logic [31:0] dat;
        logic [31:0] exp_v;
        data_t       rdat;
        data_t       saved;
        rst_n  = 1'b0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        wb_adr = '0;
        wb_sel = '0;
        wb_dat = '0;
        btn    = 1'b0;
        lineno = 0;
        n_cmds = 0;
        saved  = '0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        fd = $fopen("soc_testdata.txt", "r");
        if (fd == 0) begin
            fail_run("cannot open soc_testdata.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            lineno++;
            if ($fgets(line, fd) > 0 && line.len() > 1 && line.getc(0) != 8'h23) begin
                if ($sscanf(line, "%h %h %h %h %h", cmd, adr, sel, dat, exp_v) != 5) begin
                    fail_run($sformatf("data line %0d is malformed", lineno));
                end
                name = $sformatf("%s_line%0d", step_label(cmd), lineno);
                n_cmds++;
                case (cmd)
                    32'h0: bus_cycle(1'b1, adr, sel[3:0], dat, rdat, ack_cycle);
                    32'h1: begin
                        bus_cycle(1'b0, adr, sel[3:0], dat, rdat, ack_cycle);
                        check_value(name, exp_v, rdat);
                    end
                    32'h2: begin
                        @(negedge clk);
                        check_value(name, exp_v, {16'h0, gpio_addr, gpio_out});
                    end
                    32'h3: wait_irq(int'(adr), exp_v[0]);
                    32'h4: begin
                        @(negedge clk);
                        check_value(name, exp_v, irq);
                    end
                    32'h5: begin
                        @(posedge clk);
                        btn <= dat[0];
                    end
                    32'h6: begin    // second byte pushed while the first is on the line
                        fork
                            bus_cycle(1'b1, adr, sel[3:0], dat, rdat, ack_cycle);
                            capture_frame(name, exp_v[7:0], frame_end);
                        join
                        check_value({name, "_order"}, 32'h1, {31'h0, ack_cycle > frame_end});
                    end
                    32'h7: capture_frame(name, exp_v[7:0], frame_end);
                    32'h8: repeat (dat) @(posedge clk);
                    32'h9: begin
                        bus_cycle(1'b0, adr, sel[3:0], dat, rdat, ack_cycle);
                        saved = rdat;
                    end
                    32'ha: begin
                        bus_cycle(1'b0, adr, sel[3:0], dat, rdat, ack_cycle);
                        check_value(name, 32'h1, {31'h0, rdat > saved});
                    end
                    default: fail_run($sformatf("unknown command %0h on line %0d", cmd, lineno));
                endcase
            end
        end
        $fclose(fd);
        if (n_cmds > 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            fail_run("no stimulus lines were read");
        end
    end

endmodule

//--- soc_props.sv
module soc_props (
    input logic                 clk,
    input logic                 rst_n_i,
    input logic                 wb_stb_i,
    input logic                 wb_ack_o,
    input logic                 uart_tx_o,
    input soc_pkg::irq_vec_t    irq_o,
    input soc_pkg::uart_state_e uart_state_i
);
    import soc_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // wishbone handshake
    //////////////////////////////////////////////////////////////////////

    ack_needs_stb: assert property (@(posedge clk) disable iff (!rst_n_i)
        wb_ack_o |-> wb_stb_i)
        else $error("acknowledge seen without a strobe");

    ack_single_cycle: assert property (@(posedge clk) disable iff (!rst_n_i)
        wb_ack_o |=> !wb_ack_o)
        else $error("acknowledge held longer than one cycle");

    // line must idle high whenever the transmitter is idle
    uart_idle_high: assert property (@(posedge clk) disable iff (!rst_n_i)
        (uart_state_i == UART_IDLE) |-> uart_tx_o)
        else $error("uart line low while transmitter idle");

    irq_quiet_after_reset: assert property (@(posedge clk)
        $rose(rst_n_i) |-> (irq_o == '0) ##1 (irq_o == '0))
        else $error("interrupt vector not clear after reset");

endmodule

//--- soc_platform.sv
`include "soc_consts.svh"

module soc_platform (
    input  logic             clk,
    input  logic             rst_n_i,
    input  logic             wb_cyc_i,
    input  logic             wb_stb_i,
    input  logic             wb_we_i,
    input  soc_pkg::addr_t   wb_adr_i,
    input  soc_pkg::sel_t    wb_sel_i,
    input  soc_pkg::data_t   wb_dat_i,
    output soc_pkg::data_t   wb_dat_o,
    output logic             wb_ack_o,
    input  logic             btn_i,
    output logic [7:0]       gpio_out_o,
    output logic [7:0]       gpio_addr_o,
    output logic             uart_tx_o,
    output soc_pkg::irq_vec_t irq_o
);
    logic mti;
    logic mei;

    wb_if m_bus ();
    wb_if ram_bus ();
    wb_if rtc_bus ();
    wb_if per_bus ();

    // external master onto the internal bus
    assign m_bus.cyc   = wb_cyc_i;
    assign m_bus.stb   = wb_stb_i;
    assign m_bus.we    = wb_we_i;
    assign m_bus.adr   = wb_adr_i;
    assign m_bus.sel   = wb_sel_i;
    assign m_bus.dat_w = wb_dat_i;
    assign wb_dat_o    = m_bus.dat_r;
    assign wb_ack_o    = m_bus.ack;

    always_comb begin
        irq_o               = '0;
        irq_o[`IRQ_MTI_BIT] = mti;      // machine timer
        irq_o[`IRQ_MEI_BIT] = mei;      // button
    end

    //////////////////////////////////////////////////////////////////////
    // decode and slaves
    //////////////////////////////////////////////////////////////////////

    bus_decoder bus_decoder_i (
        .m      (m_bus.slave),
        .ram_s  (ram_bus.master),
        .rtc_s  (rtc_bus.master),
        .per_s  (per_bus.master)
    );

    data_ram #(
        .words  (`RAM_WORDS)
    ) data_ram_i (
        .clk    (clk),
        .s      (ram_bus.slave)
    );

    rtc_timer rtc_timer_i (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .s       (rtc_bus.slave),
        .mti_o   (mti)
    );

    periph_ctrl #(
        .uart_div (`UART_DIV)
    ) periph_ctrl_i (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .s           (per_bus.slave),
        .btn_i       (btn_i),
        .gpio_out_o  (gpio_out_o),
        .gpio_addr_o (gpio_addr_o),
        .uart_tx_o   (uart_tx_o),
        .mei_o       (mei)
    );

endmodule

//--- periph_ctrl.sv
`include "soc_consts.svh"

module periph_ctrl #(
    parameter int unsigned uart_div = `UART_DIV
) (
    input  logic       clk,
    input  logic       rst_n_i,
    wb_if.slave        s,
    input  logic       btn_i,
    output logic [7:0] gpio_out_o,
    output logic [7:0] gpio_addr_o,
    output logic       uart_tx_o,
    output logic       mei_o
);
    import soc_pkg::*;

    localparam int unsigned cw = $clog2(uart_div);

    logic [4:0]    off;
    logic          ack_q;
    logic          req;
    logic          uart_wr;
    logic          xfer;
    logic          wr;
    data_t         rd_data;
    data_t         dat_r_q;
    logic [7:0]    gpio_out;
    logic [7:0]    gpio_addr;
    logic          btn_meta;
    logic          btn_sync;
    logic          btn_prev;
    logic          pending;
    uart_state_e   uart_state;
    logic [cw-1:0] div_cnt;
    logic [2:0]    bit_idx;
    logic [7:0]    shreg;
    logic          tx_q;
    logic          busy;
    logic          bit_done;

    assign off      = s.adr[4:0];
    assign req      = s.cyc & s.stb & ~ack_q;
    assign busy     = (uart_state != UART_IDLE);
    assign uart_wr  = req & s.we & (off == `PER_UART_DATA);
    assign xfer     = req & ~(uart_wr & busy);   // hold ack off while a frame is out
    assign wr       = xfer & s.we;
    assign bit_done = (div_cnt == cw'(uart_div - 1));

    always_comb begin
        case (off)
            `PER_GPIO_OUT:  rd_data = {24'h0, gpio_out};
            `PER_GPIO_ADDR: rd_data = {24'h0, gpio_addr};
            `PER_BTN:       rd_data = {30'h0, pending, btn_sync};
            `PER_UART_STAT: rd_data = {31'h0, busy};
            default:        rd_data = '0;   // uart data is write only
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q     <= 1'b0;
            gpio_out  <= '0;
            gpio_addr <= '0;
            btn_meta  <= 1'b0;
            btn_sync  <= 1'b0;
            btn_prev  <= 1'b0;
            pending   <= 1'b0;
        end else begin
            ack_q    <= xfer;
            btn_meta <= btn_i;
            btn_sync <= btn_meta;
            btn_prev <= btn_sync;
            if (wr && s.sel[0] && off == `PER_GPIO_OUT) begin
                gpio_out <= s.dat_w[7:0];
            end
            if (wr && s.sel[0] && off == `PER_GPIO_ADDR) begin
                gpio_addr <= s.dat_w[7:0];
            end
            // a fresh edge wins over a clear in the same cycle
            pending <= (btn_sync & ~btn_prev) |
                       (pending & ~(wr && off == `PER_BTN && s.dat_w[1]));
        end
    end

    always_ff @(posedge clk) begin
        if (xfer) begin
            dat_r_q <= rd_data;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // uart transmitter, 8N1, lsb first
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            uart_state <= UART_IDLE;
            div_cnt    <= '0;
            bit_idx    <= '0;
            shreg      <= '0;
            tx_q       <= 1'b1;             // line idles high
        end else begin
            div_cnt <= bit_done ? '0 : div_cnt + 1'b1;
            case (uart_state)
                UART_IDLE: begin
                    div_cnt <= '0;
                    if (uart_wr && xfer) begin
                        shreg      <= s.dat_w[7:0];
                        tx_q       <= 1'b0;     // start bit
                        uart_state <= UART_START;
                    end
                end
                UART_START: begin
                    if (bit_done) begin
                        tx_q       <= shreg[0];
                        bit_idx    <= '0;
                        uart_state <= UART_DATA;
                    end
                end
                UART_DATA: begin
                    if (bit_done) begin
                        if (bit_idx == 3'd7) begin
                            tx_q       <= 1'b1;     // stop bit
                            uart_state <= UART_STOP;
                        end else begin
                            tx_q    <= shreg[1];
                            shreg   <= shreg >> 1;
                            bit_idx <= bit_idx + 3'd1;
                        end
                    end
                end
                UART_STOP: begin
                    if (bit_done) begin
                        uart_state <= UART_IDLE;
                    end
                end
                default: uart_state <= UART_IDLE;
            endcase
        end
    end

    assign s.ack       = ack_q;
    assign s.dat_r     = dat_r_q;
    assign gpio_out_o  = gpio_out;
    assign gpio_addr_o = gpio_addr;
    assign uart_tx_o   = tx_q;
    assign mei_o       = pending;

endmodule

//--- rtc_timer.sv
`include "soc_consts.svh"

module rtc_timer (
    input  logic clk,
    input  logic rst_n_i,
    wb_if.slave  s,
    output logic mti_o
);
    import soc_pkg::*;

    logic [63:0] mtime;
    logic [63:0] mtimecmp;
    logic [3:0]  off;
    logic        ack_q;
    logic        req;
    logic        wr;
    logic        mti_q;
    data_t       rd_data;
    data_t       dat_r_q;

    assign off = s.adr[3:0];
    assign req = s.cyc & s.stb & ~ack_q;
    assign wr  = req & s.we;

    always_comb begin
        case (off)
            `RTC_MTIME_LO: rd_data = mtime[31:0];
            `RTC_MTIME_HI: rd_data = mtime[63:32];
            `RTC_CMP_LO:   rd_data = mtimecmp[31:0];
            `RTC_CMP_HI:   rd_data = mtimecmp[63:32];
            default:       rd_data = '0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // counter and compare registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mtime    <= '0;
            mtimecmp <= '1;         // compare parked at max, no interrupt
            ack_q    <= 1'b0;
            mti_q    <= 1'b0;
        end else begin
            ack_q <= req;
            mti_q <= (mtime >= mtimecmp);
            mtime <= mtime + 64'd1;
            if (wr) begin
                case (off)
                    `RTC_MTIME_LO: mtime <= {mtime[63:32],
                                             merge_bytes(mtime[31:0], s.dat_w, s.sel)};
                    `RTC_MTIME_HI: mtime <= {merge_bytes(mtime[63:32], s.dat_w, s.sel),
                                             mtime[31:0]};
                    `RTC_CMP_LO:   mtimecmp[31:0]  <= merge_bytes(mtimecmp[31:0],
                                                                  s.dat_w, s.sel);
                    `RTC_CMP_HI:   mtimecmp[63:32] <= merge_bytes(mtimecmp[63:32],
                                                                  s.dat_w, s.sel);
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            dat_r_q <= rd_data;
        end
    end

    assign s.ack   = ack_q;
    assign s.dat_r = dat_r_q;
    assign mti_o   = mti_q;

endmodule

//--- data_ram.sv
`include "soc_consts.svh"

module data_ram #(
    parameter int unsigned words = `RAM_WORDS
) (
    input logic  clk,
    wb_if.slave  s
);
    import soc_pkg::*;

    localparam int unsigned aw = $clog2(words);

    data_t          mem [words];
    data_t          dat_r_q;
    logic           ack_q;
    logic [aw-1:0]  idx;
    logic           req;

    assign idx = aw'((s.adr >> 2) % words);     // word index wraps at the depth
    assign req = s.cyc & s.stb & ~ack_q;        // new transfer this cycle

    always_ff @(posedge clk) begin
        ack_q <= req;
    end

    always_ff @(posedge clk) begin
        if (req) begin
            if (s.we) begin
                mem[idx] <= merge_bytes(mem[idx], s.dat_w, s.sel);
            end
            dat_r_q <= mem[idx];    // old word on a write
        end
    end

    assign s.ack   = ack_q;
    assign s.dat_r = dat_r_q;

endmodule

//--- bus_decoder.sv
`include "soc_consts.svh"

module bus_decoder (
    wb_if.slave  m,
    wb_if.master ram_s,
    wb_if.master rtc_s,
    wb_if.master per_s
);
    logic [3:0] region;
    logic       sel_ram;
    logic       sel_rtc;
    logic       sel_per;

    assign region = m.adr[31:28];

    always_comb begin
        sel_ram = 1'b0;
        sel_rtc = 1'b0;
        sel_per = 1'b0;
        if (m.cyc) begin
            if (region < `RAM_REGION_END) begin
                sel_ram = 1'b1;
            end else if (region < `RTC_REGION_END) begin
                sel_rtc = 1'b1;
            end else begin
                sel_per = 1'b1;  // everything above the timer window
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // master side fan out, strobe only to the chosen slave
    //////////////////////////////////////////////////////////////////////

    assign ram_s.cyc   = m.cyc;
    assign ram_s.stb   = m.stb & sel_ram;
    assign ram_s.we    = m.we;
    assign ram_s.adr   = m.adr;
    assign ram_s.dat_w = m.dat_w;
    assign ram_s.sel   = m.sel;

    assign rtc_s.cyc   = m.cyc;
    assign rtc_s.stb   = m.stb & sel_rtc;
    assign rtc_s.we    = m.we;
    assign rtc_s.adr   = m.adr;
    assign rtc_s.dat_w = m.dat_w;
    assign rtc_s.sel   = m.sel;

    assign per_s.cyc   = m.cyc;
    assign per_s.stb   = m.stb & sel_per;
    assign per_s.we    = m.we;
    assign per_s.adr   = m.adr;
    assign per_s.dat_w = m.dat_w;
    assign per_s.sel   = m.sel;

    //////////////////////////////////////////////////////////////////////
    // return path, follows the address held for the current cycle
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        if (sel_ram) begin
            m.dat_r = ram_s.dat_r;
            m.ack   = ram_s.ack;
        end else if (sel_rtc) begin
            m.dat_r = rtc_s.dat_r;
            m.ack   = rtc_s.ack;
        end else if (sel_per) begin
            m.dat_r = per_s.dat_r;
            m.ack   = per_s.ack;
        end else begin
            m.dat_r = '0;     // no cycle open
            m.ack   = 1'b0;
        end
    end

endmodule

//--- wb_if.sv
interface wb_if;
    import soc_pkg::*;

    logic  cyc;     // bus cycle in progress
    logic  stb;     // transfer request
    logic  we;      // write when high
    addr_t adr;
    data_t dat_w;   // master to slave
    data_t dat_r;   // slave to master
    sel_t  sel;
    logic  ack;     // one cycle per transfer

    modport master (
        output cyc,
        output stb,
        output we,
        output adr,
        output dat_w,
        output sel,
        input  dat_r,
        input  ack
    );

    modport slave (
        input  cyc,
        input  stb,
        input  we,
        input  adr,
        input  dat_w,
        input  sel,
        output dat_r,
        output ack
    );

endinterface

//--- soc_pkg.sv
package soc_pkg;

    typedef logic [31:0] addr_t;      // byte address
    typedef logic [31:0] data_t;      // bus word
    typedef logic [3:0]  sel_t;       // one bit per byte lane
    typedef logic [31:0] irq_vec_t;   // interrupt lines seen by the core

    typedef enum logic [1:0] {
        UART_IDLE,
        UART_START,
        UART_DATA,
        UART_STOP
    } uart_state_e;

    // overlay the selected byte lanes of new_w onto old_w
    function automatic data_t merge_bytes(data_t old_w, data_t new_w, sel_t sel);
        data_t res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

endpackage

//--- soc_consts.svh
`ifndef SOC_CONSTS_SVH
`define SOC_CONSTS_SVH

//////////////////////////////////////////////////////////////////////
// address map, top nibble of the byte address
//////////////////////////////////////////////////////////////////////

`define RAM_REGION_END  4'h2    // first nibble past the data ram
`define RTC_REGION_END  4'h8    // first nibble of the peripheral block

`define RAM_WORDS       256     // default data ram depth in words

// machine timer register offsets
`define RTC_MTIME_LO    4'h0
`define RTC_MTIME_HI    4'h4
`define RTC_CMP_LO      4'h8
`define RTC_CMP_HI      4'hC

// peripheral register offsets
`define PER_GPIO_OUT    5'h00
`define PER_GPIO_ADDR   5'h04
`define PER_BTN         5'h08
`define PER_UART_DATA   5'h0C
`define PER_UART_STAT   5'h10

`define UART_DIV        16      // clocks per uart bit

`define IRQ_MTI_BIT     7
`define IRQ_MEI_BIT     11

`endif
